//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_reg_block
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- axi4lite_slave.sv
module axi4lite_slave (
  input  logic                  clk,
  input  logic                  i_reset,
  // Write address and data.
  input  logic                  i_awvalid,
  output logic                  o_awready,
  input  reg_block_pkg::id_t    i_awid,
  input  reg_block_pkg::addr_t  i_awaddr,
  input  logic [2:0]            i_awprot,
  input  logic                  i_wvalid,
  output logic                  o_wready,
  input  reg_block_pkg::data_t  i_wdata,
  input  reg_block_pkg::strb_t  i_wstrb,
  // Write response.
  output logic                  o_bvalid,
  input  logic                  i_bready,
  output reg_block_pkg::id_t    o_bid,
  output reg_block_pkg::resp_t  o_bresp,
  // Read address.
  input  logic                  i_arvalid,
  output logic                  o_arready,
  input  reg_block_pkg::id_t    i_arid,
  input  reg_block_pkg::addr_t  i_araddr,
  input  logic [2:0]            i_arprot,
  // Read data.
  output logic                  o_rvalid,
  input  logic                  i_rready,
  output reg_block_pkg::id_t    o_rid,
  output reg_block_pkg::resp_t  o_rresp,
  output reg_block_pkg::data_t  o_rdata,
  // Register access.
  input  logic                  i_hit,
  input  reg_block_pkg::data_t  i_rdata,
  output logic                  o_access_valid,
  output logic                  o_access_write,
  output reg_block_pkg::addr_t  o_access_addr,
  output reg_block_pkg::data_t  o_access_wdata,
  output reg_block_pkg::strb_t  o_access_strb
);

  import reg_block_pkg::*;

  logic  write_accept;
  logic  read_accept;
  resp_t access_resp;

  ////////////////////////////////
  // Accept.
  ////////////////////////////////

  // AW and W are taken together, writes win over reads.
  assign write_accept = i_awvalid && i_wvalid && !o_bvalid;
  assign read_accept  = i_arvalid && !o_rvalid && !write_accept;

  assign o_awready = write_accept;
  assign o_wready  = write_accept;
  assign o_arready = read_accept;

  assign o_access_valid = write_accept || read_accept;
  assign o_access_write = write_accept;
  assign o_access_addr  = write_accept ? i_awaddr : i_araddr;
  assign o_access_wdata = i_wdata;
  assign o_access_strb  = i_wstrb;

  assign access_resp = i_hit ? RESP_OKAY : RESP_SLVERR;

  ////////////////////////////////
  // Write response.
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_bvalid <= 1'b0;
    end else if (write_accept) begin
      o_bvalid <= 1'b1;
    end else if (i_bready) begin
      o_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (write_accept) begin
      o_bid   <= i_awid;
      o_bresp <= access_resp;
    end
  end

  ////////////////////////////////
  // Read response.
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_rvalid <= 1'b0;
    end else if (read_accept) begin
      o_rvalid <= 1'b1;
    end else if (i_rready) begin
      o_rvalid <= 1'b0;
    end
  end

  // Data is sampled on the accept edge.
  always_ff @(posedge clk) begin
    if (read_accept) begin
      o_rid   <= i_arid;
      o_rresp <= access_resp;
      o_rdata <= i_rdata;
    end
  end

endmodule

//--- reg_block_pkg.sv
package reg_block_pkg;

  ////////////////////////////////
  // Bus widths.
  ////////////////////////////////

  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  id_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  ////////////////////////////////
  // Register map.
  ////////////////////////////////

  // Byte offsets from the block base.
  localparam addr_t OFFSET_CONTROL = 16'h0000;
  localparam addr_t OFFSET_STATUS  = 16'h0004;
  localparam addr_t OFFSET_IRQ     = 16'h0008;
  localparam addr_t OFFSET_COMMAND = 16'h000C;
  localparam addr_t OFFSET_SCRATCH = 16'h0010;

  localparam int NUM_REGS = 5;

  typedef logic [NUM_REGS-1:0] reg_sel_t;

  // Bit positions in the one-hot select.
  localparam int REG_CONTROL = 0;
  localparam int REG_STATUS  = 1;
  localparam int REG_IRQ     = 2;
  localparam int REG_COMMAND = 3;
  localparam int REG_SCRATCH = 4;

  ////////////////////////////////
  // Hardware side.
  ////////////////////////////////

  typedef logic [3:0] irq_t;
  typedef logic [7:0] status_t;

endpackage

//--- reg_block_top.sv
module reg_block_top #(
  parameter reg_block_pkg::addr_t BASE_ADDRESS      = 16'h1000,
  parameter reg_block_pkg::data_t DEFAULT_READ_DATA = 32'hDEAD_BEAF,
  parameter reg_block_pkg::data_t CONTROL_RESET     = 32'h0000_0005
) (
  input  logic                   clk,
  input  logic                   i_reset,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  reg_block_pkg::id_t     i_awid,
  input  reg_block_pkg::addr_t   i_awaddr,
  input  logic [2:0]             i_awprot,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  input  reg_block_pkg::data_t   i_wdata,
  input  reg_block_pkg::strb_t   i_wstrb,
  output logic                   o_bvalid,
  input  logic                   i_bready,
  output reg_block_pkg::id_t     o_bid,
  output reg_block_pkg::resp_t   o_bresp,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  input  reg_block_pkg::id_t     i_arid,
  input  reg_block_pkg::addr_t   i_araddr,
  input  logic [2:0]             i_arprot,
  output logic                   o_rvalid,
  input  logic                   i_rready,
  output reg_block_pkg::id_t     o_rid,
  output reg_block_pkg::resp_t   o_rresp,
  output reg_block_pkg::data_t   o_rdata,
  output logic [3:0]             o_control_mode,
  output logic                   o_control_enable,
  output logic                   o_irq,
  output logic                   o_command_trigger,
  input  reg_block_pkg::status_t i_status,
  input  reg_block_pkg::irq_t    i_irq_set
);

  import reg_block_pkg::*;

  logic     access_valid;
  logic     access_write;
  addr_t    access_addr;
  data_t    access_wdata;
  strb_t    access_strb;
  reg_sel_t select;
  logic     hit;
  data_t    field_rdata;

  axi4lite_slave slave_i (
    .clk            (clk          ),
    .i_reset        (i_reset      ),
    .i_awvalid      (i_awvalid    ),
    .o_awready      (o_awready    ),
    .i_awid         (i_awid       ),
    .i_awaddr       (i_awaddr     ),
    .i_awprot       (i_awprot     ),
    .i_wvalid       (i_wvalid     ),
    .o_wready       (o_wready     ),
    .i_wdata        (i_wdata      ),
    .i_wstrb        (i_wstrb      ),
    .o_bvalid       (o_bvalid     ),
    .i_bready       (i_bready     ),
    .o_bid          (o_bid        ),
    .o_bresp        (o_bresp      ),
    .i_arvalid      (i_arvalid    ),
    .o_arready      (o_arready    ),
    .i_arid         (i_arid       ),
    .i_araddr       (i_araddr     ),
    .i_arprot       (i_arprot     ),
    .o_rvalid       (o_rvalid     ),
    .i_rready       (i_rready     ),
    .o_rid          (o_rid        ),
    .o_rresp        (o_rresp      ),
    .o_rdata        (o_rdata      ),
    .i_hit          (hit          ),
    .i_rdata        (field_rdata  ),
    .o_access_valid (access_valid ),
    .o_access_write (access_write ),
    .o_access_addr  (access_addr  ),
    .o_access_wdata (access_wdata ),
    .o_access_strb  (access_strb  )
  );

  reg_decoder #(
    .BASE_ADDRESS (BASE_ADDRESS )
  ) decoder_i (
    .i_addr   (access_addr  ),
    .i_valid  (access_valid ),
    .o_select (select       ),
    .o_hit    (hit          )
  );

  reg_fields #(
    .DEFAULT_READ_DATA  (DEFAULT_READ_DATA  ),
    .CONTROL_RESET      (CONTROL_RESET      )
  ) fields_i (
    .clk                (clk                ),
    .i_reset            (i_reset            ),
    .i_select           (select             ),
    .i_write            (access_write       ),
    .i_wdata            (access_wdata       ),
    .i_strb             (access_strb        ),
    .i_status           (i_status           ),
    .i_irq_set          (i_irq_set          ),
    .o_rdata            (field_rdata        ),
    .o_control_mode     (o_control_mode     ),
    .o_control_enable   (o_control_enable   ),
    .o_irq              (o_irq              ),
    .o_command_trigger  (o_command_trigger  )
  );

endmodule

//--- reg_decoder.sv
module reg_decoder #(
  parameter reg_block_pkg::addr_t BASE_ADDRESS = 16'h1000
) (
  input  reg_block_pkg::addr_t    i_addr,
  input  logic                    i_valid,
  output reg_block_pkg::reg_sel_t o_select,
  output logic                    o_hit
);

  import reg_block_pkg::*;

  addr_t offset;
  addr_t word_offset;
  logic  in_range;

  assign offset      = i_addr - BASE_ADDRESS;
  // Low two bits do not take part in the decode.
  assign word_offset = {offset[15:2], 2'b00};

  // Window covers the last register's full word.
  assign in_range = (i_addr >= BASE_ADDRESS) &&
                    (word_offset <= OFFSET_SCRATCH);

  assign o_hit = in_range;

  always_comb begin
    o_select = '0;
    if (i_valid && in_range) begin
      case (word_offset)
        OFFSET_CONTROL: o_select[REG_CONTROL] = 1'b1;
        OFFSET_STATUS:  o_select[REG_STATUS]  = 1'b1;
        OFFSET_IRQ:     o_select[REG_IRQ]     = 1'b1;
        OFFSET_COMMAND: o_select[REG_COMMAND] = 1'b1;
        OFFSET_SCRATCH: o_select[REG_SCRATCH] = 1'b1;
        default:        o_select = '0;
      endcase
    end
  end

endmodule

//--- reg_fields.sv
module reg_fields #(
  parameter reg_block_pkg::data_t DEFAULT_READ_DATA = 32'hDEAD_BEAF,
  parameter reg_block_pkg::data_t CONTROL_RESET     = 32'h0000_0005
) (
  input  logic                    clk,
  input  logic                    i_reset,
  input  reg_block_pkg::reg_sel_t i_select,
  input  logic                    i_write,
  input  reg_block_pkg::data_t    i_wdata,
  input  reg_block_pkg::strb_t    i_strb,
  input  reg_block_pkg::status_t  i_status,
  input  reg_block_pkg::irq_t     i_irq_set,
  output reg_block_pkg::data_t    o_rdata,
  output logic [3:0]              o_control_mode,
  output logic                    o_control_enable,
  output logic                    o_irq,
  output logic                    o_command_trigger
);

  import reg_block_pkg::*;

  logic [4:0] control_q;
  irq_t       irq_q;
  irq_t       irq_clear;
  data_t      scratch_q;

  logic       control_write;
  logic       irq_write;
  logic       command_write;
  logic       scratch_write;

  assign control_write = i_write && i_select[REG_CONTROL];
  assign irq_write     = i_write && i_select[REG_IRQ];
  assign command_write = i_write && i_select[REG_COMMAND];
  assign scratch_write = i_write && i_select[REG_SCRATCH];

  ////////////////////////////////
  // Control.
  ////////////////////////////////

  // Mode and enable both live in byte 0.
  always_ff @(posedge clk) begin
    if (i_reset) begin
      control_q <= CONTROL_RESET[4:0];
    end else if (control_write && i_strb[0]) begin
      control_q <= i_wdata[4:0];
    end
  end

  assign o_control_mode   = control_q[3:0];
  assign o_control_enable = control_q[4];

  ////////////////////////////////
  // Interrupts.
  ////////////////////////////////

  assign irq_clear = (irq_write && i_strb[0]) ? i_wdata[3:0] : '0;

  // Hardware set wins over a clear.
  always_ff @(posedge clk) begin
    if (i_reset) begin
      irq_q <= '0;
    end else begin
      irq_q <= (irq_q & ~irq_clear) | i_irq_set;
    end
  end

  assign o_irq = |irq_q;

  ////////////////////////////////
  // Command.
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_command_trigger <= 1'b0;
    end else begin
      o_command_trigger <= command_write && i_strb[0] && i_wdata[0];
    end
  end

  ////////////////////////////////
  // Scratch.
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_reset) begin
      scratch_q <= '0;
    end else if (scratch_write) begin
      for (int i = 0; i < 4; i++) begin
        if (i_strb[i]) begin
          scratch_q[8*i+:8] <= i_wdata[8*i+:8];
        end
      end
    end
  end

  ////////////////////////////////
  // Read mux.
  ////////////////////////////////

  // Select is one-hot, empty on a miss.
  always_comb begin
    case (1'b1)
      i_select[REG_CONTROL]: o_rdata = data_t'(control_q);
      i_select[REG_STATUS]:  o_rdata = data_t'(i_status);
      i_select[REG_IRQ]:     o_rdata = data_t'(irq_q);
      i_select[REG_COMMAND]: o_rdata = '0;
      i_select[REG_SCRATCH]: o_rdata = scratch_q;
      default:               o_rdata = DEFAULT_READ_DATA;
    endcase
  end

endmodule

//--- sim.f
reg_block_pkg.sv
axi4lite_slave.sv
reg_decoder.sv
reg_fields.sv
reg_block_top.sv
tb_reg_block.sv

//--- tb_reg_block.sv
module tb_reg_block;

  timeunit 1ns;
  timeprecision 1ps;

  import reg_block_pkg::*;

  localparam addr_t BASE_ADDRESS      = 16'h1000;
  localparam data_t DEFAULT_READ_DATA = 32'hDEAD_BEAF;
  localparam data_t CONTROL_RESET     = 32'h0000_0005;
  // About 400 transactions of at most 12 cycles plus margin.
  localparam int    MAX_CYCLES        = 20_000;

  logic    clk = 1'b0;
  logic    i_reset;
  logic    i_awvalid;
  logic    o_awready;
  id_t     i_awid;
  addr_t   i_awaddr;
  logic [2:0] i_awprot;
  logic    i_wvalid;
  logic    o_wready;
  data_t   i_wdata;
  strb_t   i_wstrb;
  logic    o_bvalid;
  logic    i_bready;
  id_t     o_bid;
  resp_t   o_bresp;
  logic    i_arvalid;
  logic    o_arready;
  id_t     i_arid;
  addr_t   i_araddr;
  logic [2:0] i_arprot;
  logic    o_rvalid;
  logic    i_rready;
  id_t     o_rid;
  resp_t   o_rresp;
  data_t   o_rdata;
  logic [3:0] o_control_mode;
  logic    o_control_enable;
  logic    o_irq;
  logic    o_command_trigger;
  status_t i_status;
  irq_t    i_irq_set;

  // Reference model.
  data_t model_control;
  irq_t  model_irq;
  data_t model_scratch;
  logic  exp_trigger;
  data_t exp_rdata;
  logic  aw_fire = 1'b0;
  logic  ar_fire = 1'b0;
  int    cycle_count = 0;

  always #20 clk = ~clk;

  reg_block_top #(
    .BASE_ADDRESS      (BASE_ADDRESS      ),
    .DEFAULT_READ_DATA (DEFAULT_READ_DATA ),
    .CONTROL_RESET     (CONTROL_RESET     )
  ) dut_i (
    .clk (clk), .i_reset (i_reset),
    .i_awvalid (i_awvalid), .o_awready (o_awready), .i_awid (i_awid),
    .i_awaddr (i_awaddr), .i_awprot (i_awprot),
    .i_wvalid (i_wvalid), .o_wready (o_wready), .i_wdata (i_wdata), .i_wstrb (i_wstrb),
    .o_bvalid (o_bvalid), .i_bready (i_bready), .o_bid (o_bid), .o_bresp (o_bresp),
    .i_arvalid (i_arvalid), .o_arready (o_arready), .i_arid (i_arid),
    .i_araddr (i_araddr), .i_arprot (i_arprot),
    .o_rvalid (o_rvalid), .i_rready (i_rready), .o_rid (o_rid),
    .o_rresp (o_rresp), .o_rdata (o_rdata),
    .o_control_mode (o_control_mode), .o_control_enable (o_control_enable),
    .o_irq (o_irq), .o_command_trigger (o_command_trigger),
    .i_status (i_status), .i_irq_set (i_irq_set)
  );

  task automatic report_error(input string msg);
    $display("Fail %0t: %s", $time, msg);
    $display("Finished with errors");
    $fatal(1, "Check failed");
  endtask

  // Word index inside the map or -1 outside it.
  function automatic int reg_index(input addr_t addr);
    if (addr < BASE_ADDRESS || addr > BASE_ADDRESS + 16'h0013) begin
      return -1;
    end
    return int'((addr - BASE_ADDRESS) >> 2);
  endfunction

  function automatic resp_t expected_resp(input addr_t addr);
    return (reg_index(addr) >= 0) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  function automatic data_t model_read(input int idx);
    case (idx)
      0:       return model_control;
      1:       return data_t'(i_status);
      2:       return data_t'(model_irq);
      3:       return '0;
      4:       return model_scratch;
      default: return DEFAULT_READ_DATA;
    endcase
  endfunction

  function automatic data_t merge_bytes(input data_t old_value, input data_t new_value,
                                        input strb_t strb);
    data_t result;
    result = old_value;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b+:8] = new_value[8*b+:8];
      end
    end
    return result;
  endfunction

  function automatic addr_t unmapped_addr();
    if ($urandom_range(0, 1) == 0) begin
      return addr_t'($urandom_range(0, int'(BASE_ADDRESS) - 1));
    end
    return addr_t'($urandom_range(int'(BASE_ADDRESS) + 32'h14, 32'hFFFF));
  endfunction

  ////////////////////////////////
  // Model and monitor.
  ////////////////////////////////

  always @(posedge clk) begin : model_update
    irq_t clear_bits;
    int   idx;
    clear_bits = '0;
    if (i_reset) begin
      model_control = CONTROL_RESET & 32'h0000_001F;
      model_irq     = '0;
      model_scratch = '0;
      exp_trigger   = 1'b0;
    end else begin
      exp_trigger = 1'b0;
      // Read data is taken before this edge updates anything.
      if (ar_fire) begin
        exp_rdata = model_read(reg_index(i_araddr));
      end
      if (aw_fire) begin
        idx = reg_index(i_awaddr);
        if (idx == 0 && i_wstrb[0]) begin
          model_control = data_t'(i_wdata[4:0]);
        end
        if (idx == 2 && i_wstrb[0]) begin
          clear_bits = i_wdata[3:0];
        end
        if (idx == 3) begin
          exp_trigger = i_wstrb[0] && i_wdata[0];
        end
        if (idx == 4) begin
          model_scratch = merge_bytes(model_scratch, i_wdata, i_wstrb);
        end
      end
      model_irq = (model_irq & ~clear_bits) | i_irq_set;
    end
  end

  always @(negedge clk) begin
    aw_fire = i_awvalid && o_awready && i_wvalid && o_wready;
    ar_fire = i_arvalid && o_arready;
    if (!i_reset) begin
      assert (o_wready === o_awready)
        else report_error("wready and awready differ");
      assert (o_command_trigger === exp_trigger)
        else report_error("command trigger differs from model");
      assert (o_irq === (|model_irq))
        else report_error("o_irq differs from OR of model irq bits");
      assert ({o_control_enable, o_control_mode} === model_control[4:0])
        else report_error("control outputs differ from model");
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the test did not complete within %0d cycles.", MAX_CYCLES);
      $display("Finished with errors");
      $fatal(1, "Simulation timed out");
    end
  end

  ////////////////////////////////
  // Bus tasks.
  ////////////////////////////////

  // Starts and ends 2 ns after a rising edge.
  task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                           input id_t id, input irq_t irq_set);
    int delay;
    delay = $urandom_range(0, 3);
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    i_awid    = id;
    i_awaddr  = addr;
    i_awprot  = 3'($urandom);
    i_wdata   = data;
    i_wstrb   = strb;
    i_irq_set = irq_set;
    do @(negedge clk); while (!(o_awready && o_wready));
    @(posedge clk);
    #2;
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    i_irq_set = '0;
    repeat (delay) begin
      @(posedge clk);
      #2;
    end
    i_bready = 1'b1;
    do @(negedge clk); while (!o_bvalid);
    assert (o_bid === id) else report_error("write response ID mismatch");
    assert (o_bresp === expected_resp(addr)) else report_error("write response code mismatch");
    @(posedge clk);
    #2;
    i_bready = 1'b0;
  endtask

  task automatic axi_read(input addr_t addr, input id_t id, output data_t data);
    int delay;
    delay = $urandom_range(0, 3);
    i_arvalid = 1'b1;
    i_arid    = id;
    i_araddr  = addr;
    i_arprot  = 3'($urandom);
    do @(negedge clk); while (!o_arready);
    @(posedge clk);
    #2;
    i_arvalid = 1'b0;
    repeat (delay) begin
      @(posedge clk);
      #2;
    end
    i_rready = 1'b1;
    do @(negedge clk); while (!o_rvalid);
    assert (o_rid === id) else report_error("read response ID mismatch");
    assert (o_rresp === expected_resp(addr)) else report_error("read response code mismatch");
    assert (o_rdata === exp_rdata) else report_error("read data differs from model");
    data = o_rdata;
    @(posedge clk);
    #2;
    i_rready = 1'b0;
  endtask

  task automatic pulse_irq(input irq_t bits);
    i_irq_set = bits;
    @(posedge clk);
    #2;
    i_irq_set = '0;
  endtask

  ////////////////////////////////
  // Stimulus.
  ////////////////////////////////

  initial begin : stimulus
    data_t rdata;
    addr_t addr;
    int    sel;
    void'($urandom(23));
    i_reset   = 1'b1;
    i_awvalid = 1'b0;
    i_awid    = '0;
    i_awaddr  = '0;
    i_awprot  = '0;
    i_wvalid  = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_bready  = 1'b0;
    i_arvalid = 1'b0;
    i_arid    = '0;
    i_araddr  = '0;
    i_arprot  = '0;
    i_rready  = 1'b0;
    i_status  = '0;
    i_irq_set = '0;
    repeat (10) @(posedge clk);
    #2;
    i_reset = 1'b0;
    @(posedge clk);
    #2;

    assert (!o_command_trigger && !o_irq) else report_error("outputs high after reset");
    axi_read(BASE_ADDRESS + OFFSET_CONTROL, 2'd0, rdata);
    assert (rdata === CONTROL_RESET) else report_error("control reset value wrong");
    axi_read(BASE_ADDRESS + OFFSET_SCRATCH, 2'd1, rdata);
    assert (rdata === '0) else report_error("scratch reset value wrong");

    // Strobed traffic on control and scratch with random low address bits.
    repeat (150) begin
      addr = BASE_ADDRESS + (($urandom_range(0, 1) == 1) ? OFFSET_SCRATCH : OFFSET_CONTROL)
             + addr_t'($urandom_range(0, 3));
      if ($urandom_range(0, 1) == 1) begin
        axi_write(addr, data_t'($urandom), strb_t'($urandom), id_t'($urandom), '0);
      end else begin
        axi_read(addr, id_t'($urandom), rdata);
      end
    end

    repeat (30) begin
      i_status = status_t'($urandom);
      axi_read(BASE_ADDRESS + OFFSET_STATUS, id_t'($urandom), rdata);
      assert (rdata === {24'h0, i_status}) else report_error("status read mismatch");
    end

    // Sets during a clearing write exercise the collision rule.
    repeat (90) begin
      sel = $urandom_range(0, 2);
      if (sel == 0) begin
        pulse_irq(irq_t'($urandom));
      end else if (sel == 1) begin
        axi_write(BASE_ADDRESS + OFFSET_IRQ, data_t'($urandom), strb_t'($urandom),
                  id_t'($urandom), ($urandom_range(0, 1) == 1) ? irq_t'($urandom) : '0);
      end else begin
        axi_read(BASE_ADDRESS + OFFSET_IRQ, id_t'($urandom), rdata);
      end
    end

    repeat (30) begin
      if ($urandom_range(0, 2) != 0) begin
        axi_write(BASE_ADDRESS + OFFSET_COMMAND, data_t'($urandom), strb_t'($urandom),
                  id_t'($urandom), '0);
      end else begin
        axi_read(BASE_ADDRESS + OFFSET_COMMAND, id_t'($urandom), rdata);
        assert (rdata === '0) else report_error("command read not zero");
      end
    end

    repeat (40) begin
      axi_write(unmapped_addr(), data_t'($urandom), strb_t'($urandom), id_t'($urandom), '0);
      axi_read(unmapped_addr(), id_t'($urandom), rdata);
      assert (rdata === DEFAULT_READ_DATA) else report_error("unmapped read data wrong");
    end

    // Nothing may have moved from the misses.
    for (int r = 0; r < NUM_REGS; r++) begin
      axi_read(BASE_ADDRESS + addr_t'(4 * r), id_t'(r), rdata);
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule
